//--- verilog.f
src/stlb_pkg.sv
src/stlb_entry_ram.sv
src/stlb_miss_arbiter.sv
src/stlb_lookup.sv
src/stlb_refill.sv
src/stlb_top.sv
testbench/stlb_assertions.sv
testbench/tb_stlb.sv

//--- testbench/tb_stlb.sv
/*
 * shared TLB testbench with clock, reset, miss and fill sequences,
 * reference table for hit data and the closing summary
 */
`timescale 1ns/10ps

module tb_stlb;

    import stlb_pkg::*;

    localparam int STLB_SETS = 64;
    localparam int STLB_WAYS = 2;
    localparam int IDX_W     = $clog2(STLB_SETS);

    logic                clk_i;
    logic                rst_ni;
    logic                flush_i;
    logic                itlb_en_i;
    logic                dtlb_en_i;
    logic [ASID_W-1:0]   asid_i;
    logic                itlb_access_i;
    logic                itlb_hit_i;
    logic [VADDR_W-1:0]  itlb_vaddr_i;
    logic                dtlb_access_i;
    logic                dtlb_hit_i;
    logic [VADDR_W-1:0]  dtlb_vaddr_i;
    logic                ptw_update_valid_i;
    logic [VPN_W-1:0]    ptw_update_vpn_i;
    logic [ASID_W-1:0]   ptw_update_asid_i;
    stlb_pte_t           ptw_update_pte_i;
    logic                itlb_miss_o;
    logic                dtlb_miss_o;
    logic                stlb_access_o;
    logic                stlb_hit_o;
    logic                itlb_update_valid_o;
    logic [VPN_W-1:0]    itlb_update_vpn_o;
    logic [ASID_W-1:0]   itlb_update_asid_o;
    stlb_pte_t           itlb_update_pte_o;
    logic                dtlb_update_valid_o;
    logic [VPN_W-1:0]    dtlb_update_vpn_o;
    logic [ASID_W-1:0]   dtlb_update_asid_o;
    stlb_pte_t           dtlb_update_pte_o;

    // reference table with one slot per filled entry
    logic [VPN_W-1:0]  ref_vpn [$];
    logic [ASID_W-1:0] ref_asid [$];
    stlb_pte_t         ref_pte [$];
    int unsigned       err_cnt;
    int unsigned       timeout_cnt;

    stlb_top #(
        .STLB_SETS(STLB_SETS),
        .STLB_WAYS(STLB_WAYS)
    ) u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    ////////////////////
    // helpers
    ////////////////////

    // random upper bits over a fixed set index
    function automatic logic [VPN_W-1:0] make_vpn(input int set);
        return {(VPN_W-IDX_W)'($urandom()), IDX_W'(set)};
    endfunction

    function automatic stlb_pte_t rand_pte(input logic glob);
        stlb_pte_t p;
        p.ppn = PPN_W'({$urandom(), $urandom()});
        p.g   = glob;
        {p.r, p.w, p.x, p.u, p.a, p.d} = 6'($urandom());
        return p;
    endfunction

    // full vpn match and asid match unless global
    function automatic logic predict(input logic [VPN_W-1:0] vpn,
                                     input logic [ASID_W-1:0] asid, output stlb_pte_t pte);
        pte = PTE_ZERO;
        for (int k = 0; k < ref_vpn.size(); k++) begin
            if (ref_vpn[k] == vpn && (ref_asid[k] == asid || ref_pte[k].g)) begin
                pte = ref_pte[k];
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // inputs change 1 ns after the edge
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    // outputs sampled mid cycle
    task automatic settle();
        #4;
    endtask

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
        assert (got === exp) else begin
            err_cnt++;
            $display("[ERROR] %s expected %h got %h", name, exp, got);
        end
    endtask

    // both update ports against one expected side
    task automatic check_update(input logic on_itlb, input logic exp_v,
                                input logic [VPN_W-1:0] vpn, input logic [ASID_W-1:0] asid,
                                input stlb_pte_t pte);
        check_val("itlb_update_valid_o", exp_v & on_itlb, itlb_update_valid_o);
        check_val("dtlb_update_valid_o", exp_v & !on_itlb, dtlb_update_valid_o);
        if (exp_v && on_itlb) begin
            check_val("itlb_update_vpn_o", vpn, itlb_update_vpn_o);
            check_val("itlb_update_asid_o", asid, itlb_update_asid_o);
            check_val("itlb_update_pte_o", pte, itlb_update_pte_o);
        end else if (exp_v) begin
            check_val("dtlb_update_vpn_o", vpn, dtlb_update_vpn_o);
            check_val("dtlb_update_asid_o", asid, dtlb_update_asid_o);
            check_val("dtlb_update_pte_o", pte, dtlb_update_pte_o);
        end
    endtask

    task automatic wait_access();
        int cnt;
        cnt = 0;
        while (!stlb_access_o && cnt < 8) begin
            next_cycle();
            cnt++;
        end
        if (!stlb_access_o) begin
            timeout_cnt++;
            $display("timeout: stlb_access_o never rose after a miss");
        end
    endtask

    ////////////////////
    // stimulus tasks
    ////////////////////

    // one miss in cycle 0 and its result in cycle 1
    task automatic request(input logic i_acc, input logic d_acc,
                           input logic [VPN_W-1:0] vpn, input logic [ASID_W-1:0] asid);
        logic      to_itlb;
        logic      exp_hit;
        stlb_pte_t exp_pte;
        to_itlb       = i_acc & ~d_acc;
        exp_hit       = predict(vpn, asid, exp_pte);
        itlb_access_i = i_acc;
        dtlb_access_i = d_acc;
        // the side that loses carries another vpn
        itlb_vaddr_i  = {to_itlb ? vpn : ~vpn, PAGE_OFFSET_W'($urandom())};
        dtlb_vaddr_i  = {to_itlb ? ~vpn : vpn, PAGE_OFFSET_W'($urandom())};
        asid_i        = asid;
        settle();
        check_val("itlb_miss_o", to_itlb, itlb_miss_o);
        check_val("dtlb_miss_o", d_acc, dtlb_miss_o);
        next_cycle();
        itlb_access_i = 1'b0;
        dtlb_access_i = 1'b0;
        wait_access();
        settle();
        check_val("stlb_hit_o", exp_hit, stlb_hit_o);
        check_update(to_itlb, exp_hit, vpn, asid, exp_pte);
        next_cycle();
    endtask

    // walker update forwarded to the pending side in the same cycle
    task automatic fill(input logic to_itlb, input logic [VPN_W-1:0] vpn,
                        input logic [ASID_W-1:0] asid, input stlb_pte_t pte);
        ptw_update_valid_i = 1'b1;
        ptw_update_vpn_i   = vpn;
        ptw_update_asid_i  = asid;
        ptw_update_pte_i   = pte;
        settle();
        check_update(to_itlb, 1'b1, vpn, asid, pte);
        ref_vpn.push_back(vpn);
        ref_asid.push_back(asid);
        ref_pte.push_back(pte);
        next_cycle();
        ptw_update_valid_i = 1'b0;
    endtask

    // missing access on a disabled side is ignored
    task automatic disabled_side(input logic i_side);
        itlb_en_i     = !i_side;
        dtlb_en_i     = i_side;
        itlb_access_i = i_side;
        dtlb_access_i = !i_side;
        settle();
        check_val("itlb_miss_o", 1'b0, itlb_miss_o);
        check_val("dtlb_miss_o", 1'b0, dtlb_miss_o);
        next_cycle();
        itlb_en_i     = 1'b1;
        dtlb_en_i     = 1'b1;
        itlb_access_i = 1'b0;
        dtlb_access_i = 1'b0;
        next_cycle();
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        logic [VPN_W-1:0]  vpn;
        logic [ASID_W-1:0] asid;
        logic              side;
        logic [VPN_W-1:0]  way_vpn [STLB_WAYS];
        logic [ASID_W-1:0] way_asid [STLB_WAYS];
        int unsigned       total;

        void'($urandom(32'hdbb2_2fc5));
        err_cnt            = 0;
        timeout_cnt        = 0;
        rst_ni             = 1'b0;
        flush_i            = 1'b0;
        itlb_en_i          = 1'b1;
        dtlb_en_i          = 1'b1;
        asid_i             = '0;
        itlb_access_i      = 1'b0;
        itlb_hit_i         = 1'b0;
        itlb_vaddr_i       = '0;
        dtlb_access_i      = 1'b0;
        dtlb_hit_i         = 1'b0;
        dtlb_vaddr_i       = '0;
        ptw_update_valid_i = 1'b0;
        ptw_update_vpn_i   = '0;
        ptw_update_asid_i  = '0;
        ptw_update_pte_i   = PTE_ZERO;
        repeat (2) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        next_cycle();

        // miss, fill and hit on alternating sides
        for (int i = 0; i < 4; i++) begin
            vpn  = make_vpn(i + 1);
            asid = ASID_W'($urandom());
            side = i[0];
            request(side, !side, vpn, asid);
            fill(side, vpn, asid, rand_pte(1'b0));
            request(side, !side, vpn, asid);
            // data side wins when both sides miss
            request(1'b1, 1'b1, vpn, asid);
            // private entry under another asid
            request(!side, side, vpn, asid ^ 16'h0001);
        end

        // global entry hits under any asid
        vpn  = make_vpn(10);
        asid = ASID_W'($urandom());
        request(1'b0, 1'b1, vpn, asid);
        fill(1'b0, vpn, asid, rand_pte(1'b1));
        request(1'b1, 1'b0, vpn, ASID_W'($urandom()));
        request(1'b0, 1'b1, vpn, asid + 16'h0100);

        // fill every way of one set with invalid ways first
        for (int w = 0; w < STLB_WAYS; w++) begin
            way_vpn[w]  = make_vpn(20);
            way_asid[w] = ASID_W'($urandom());
            request(1'b0, 1'b1, way_vpn[w], way_asid[w]);
            fill(1'b0, way_vpn[w], way_asid[w], rand_pte(1'b0));
        end
        for (int w = 0; w < STLB_WAYS; w++) begin
            request(1'b1, 1'b0, way_vpn[w], way_asid[w]);
        end

        // flush empties the table until refilled
        flush_i = 1'b1;
        next_cycle();
        flush_i = 1'b0;
        ref_vpn.delete();
        ref_asid.delete();
        ref_pte.delete();
        for (int w = 0; w < STLB_WAYS; w++) begin
            request(1'b0, 1'b1, way_vpn[w], way_asid[w]);
        end
        fill(1'b0, way_vpn[0], way_asid[0], rand_pte(1'b0));
        request(1'b0, 1'b1, way_vpn[0], way_asid[0]);

        disabled_side(1'b1);
        disabled_side(1'b0);
        repeat (3) next_cycle();

        total = err_cnt + timeout_cnt + u_dut.u_assertions.fail_cnt;
        $display("errors: data %0d, timeouts %0d, assertions %0d",
                 err_cnt, timeout_cnt, u_dut.u_assertions.fail_cnt);
        if (total == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- testbench/stlb_assertions.sv
/*
 * concurrent checks bound into stlb_top
 * quiet outputs after reset, miss arbitration, access timing and flush
 */
`timescale 1ns/10ps

module stlb_assertions (
    input logic clk_i,
    input logic rst_ni,
    input logic flush_i,
    input logic itlb_miss_i,
    input logic dtlb_miss_i,
    input logic stlb_access_i,
    input logic stlb_hit_i,
    input logic itlb_update_valid_i,
    input logic dtlb_update_valid_i
);

    // count of failed assertions
    int unsigned fail_cnt = 0;

    // set by the first accepted miss after reset
    logic seen_miss_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            seen_miss_q <= 1'b0;
        end else if (itlb_miss_i || dtlb_miss_i) begin
            seen_miss_q <= 1'b1;
        end
    end

    ////////////////////
    // reset and arbitration
    ////////////////////

    // outputs stay quiet through reset and up to the first miss
    reset_quiet_a: assert property (@(posedge clk_i)
        !seen_miss_q |-> !stlb_access_i && !stlb_hit_i
                         && !itlb_update_valid_i && !dtlb_update_valid_i)
        else begin
            $error("control outputs active before the first miss");
            fail_cnt++;
        end

    // one miss per cycle
    one_miss_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(itlb_miss_i && dtlb_miss_i))
        else begin
            $error("itlb and dtlb miss taken in the same cycle");
            fail_cnt++;
        end

    // access is the miss delayed by exactly one cycle
    access_delay_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        stlb_access_i == $past(itlb_miss_i || dtlb_miss_i))
        else begin
            $error("stlb access does not follow a miss by one cycle");
            fail_cnt++;
        end

    ////////////////////
    // flush
    ////////////////////

    // in-flight lookup and the next one both miss after a flush
    flush_miss_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> !stlb_hit_i [*2])
        else begin
            $error("lookup hit right after a flush");
            fail_cnt++;
        end

endmodule

bind stlb_top stlb_assertions u_assertions (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .flush_i            (flush_i),
    .itlb_miss_i        (itlb_miss_o),
    .dtlb_miss_i        (dtlb_miss_o),
    .stlb_access_i      (stlb_access_o),
    .stlb_hit_i         (stlb_hit_o),
    .itlb_update_valid_i(itlb_update_valid_o),
    .dtlb_update_valid_i(dtlb_update_valid_o)
);

//--- src/stlb_top.sv
/*
 * shared TLB top: miss arbiter, lookup and refill stages
 */
`timescale 1ns/10ps

module stlb_top #(
    parameter int STLB_SETS = 64,
    parameter int STLB_WAYS = 2
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       flush_i,
    input  logic                       itlb_en_i,
    input  logic                       dtlb_en_i,
    input  logic [stlb_pkg::ASID_W-1:0]  asid_i,
    input  logic                       itlb_access_i,
    input  logic                       itlb_hit_i,
    input  logic [stlb_pkg::VADDR_W-1:0] itlb_vaddr_i,
    input  logic                       dtlb_access_i,
    input  logic                       dtlb_hit_i,
    input  logic [stlb_pkg::VADDR_W-1:0] dtlb_vaddr_i,
    input  logic                       ptw_update_valid_i,
    input  logic [stlb_pkg::VPN_W-1:0]   ptw_update_vpn_i,
    input  logic [stlb_pkg::ASID_W-1:0]  ptw_update_asid_i,
    input  stlb_pkg::stlb_pte_t         ptw_update_pte_i,
    output logic                       itlb_miss_o,
    output logic                       dtlb_miss_o,
    output logic                       stlb_access_o,
    output logic                       stlb_hit_o,
    output logic                       itlb_update_valid_o,
    output logic [stlb_pkg::VPN_W-1:0]   itlb_update_vpn_o,
    output logic [stlb_pkg::ASID_W-1:0]  itlb_update_asid_o,
    output stlb_pkg::stlb_pte_t         itlb_update_pte_o,
    output logic                       dtlb_update_valid_o,
    output logic [stlb_pkg::VPN_W-1:0]   dtlb_update_vpn_o,
    output logic [stlb_pkg::ASID_W-1:0]  dtlb_update_asid_o,
    output stlb_pkg::stlb_pte_t         dtlb_update_pte_o
);

    import stlb_pkg::*;

    // arbiter to lookup and refill
    logic                 rd_en;
    logic [VPN_W-1:0]     rd_vpn;
    logic [ASID_W-1:0]    rd_asid;
    logic                 req_itlb_q;
    logic                 req_dtlb_q;

    // lookup to refill
    logic                 lookup_valid;
    logic                 hit;
    stlb_pte_t            hit_pte;
    logic [VPN_W-1:0]     hit_vpn;
    logic [ASID_W-1:0]    hit_asid;
    logic [STLB_WAYS-1:0] wr_set_valid;

    // refill writes back into the arrays
    logic [STLB_WAYS-1:0] wr_en_way;
    logic [VPN_W-1:0]     wr_vpn;
    logic [ASID_W-1:0]    wr_asid;
    stlb_pte_t            wr_pte;

    assign stlb_hit_o = hit;

    stlb_miss_arbiter u_arbiter (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .itlb_en_i    (itlb_en_i),
        .dtlb_en_i    (dtlb_en_i),
        .asid_i       (asid_i),
        .itlb_access_i(itlb_access_i),
        .itlb_hit_i   (itlb_hit_i),
        .itlb_vaddr_i (itlb_vaddr_i),
        .dtlb_access_i(dtlb_access_i),
        .dtlb_hit_i   (dtlb_hit_i),
        .dtlb_vaddr_i (dtlb_vaddr_i),
        .itlb_miss_o  (itlb_miss_o),
        .dtlb_miss_o  (dtlb_miss_o),
        .rd_en_o      (rd_en),
        .rd_vpn_o     (rd_vpn),
        .rd_asid_o    (rd_asid),
        .stlb_access_o(stlb_access_o),
        .req_itlb_o   (req_itlb_q),
        .req_dtlb_o   (req_dtlb_q)
    );

    stlb_lookup #(
        .STLB_SETS(STLB_SETS),
        .STLB_WAYS(STLB_WAYS)
    ) u_lookup (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .rd_en_i       (rd_en),
        .rd_vpn_i      (rd_vpn),
        .rd_asid_i     (rd_asid),
        .wr_en_way_i   (wr_en_way),
        .wr_vpn_i      (wr_vpn),
        .wr_asid_i     (wr_asid),
        .wr_pte_i      (wr_pte),
        .wr_set_vpn_i  (ptw_update_vpn_i),
        .lookup_valid_o(lookup_valid),
        .hit_o         (hit),
        .hit_pte_o     (hit_pte),
        .hit_vpn_o     (hit_vpn),
        .hit_asid_o    (hit_asid),
        .wr_set_valid_o(wr_set_valid)
    );

    stlb_refill #(
        .STLB_WAYS(STLB_WAYS)
    ) u_refill (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .flush_i            (flush_i),
        .req_itlb_i         (req_itlb_q),
        .req_dtlb_i         (req_dtlb_q),
        .lookup_valid_i     (lookup_valid),
        .hit_i              (hit),
        .hit_pte_i          (hit_pte),
        .hit_vpn_i          (hit_vpn),
        .hit_asid_i         (hit_asid),
        .ptw_update_valid_i (ptw_update_valid_i),
        .ptw_update_vpn_i   (ptw_update_vpn_i),
        .ptw_update_asid_i  (ptw_update_asid_i),
        .ptw_update_pte_i   (ptw_update_pte_i),
        .wr_set_valid_i     (wr_set_valid),
        .wr_en_way_o        (wr_en_way),
        .wr_vpn_o           (wr_vpn),
        .wr_asid_o          (wr_asid),
        .wr_pte_o           (wr_pte),
        .itlb_update_valid_o(itlb_update_valid_o),
        .itlb_update_vpn_o  (itlb_update_vpn_o),
        .itlb_update_asid_o (itlb_update_asid_o),
        .itlb_update_pte_o  (itlb_update_pte_o),
        .dtlb_update_valid_o(dtlb_update_valid_o),
        .dtlb_update_vpn_o  (dtlb_update_vpn_o),
        .dtlb_update_asid_o (dtlb_update_asid_o),
        .dtlb_update_pte_o  (dtlb_update_pte_o)
    );

endmodule

//--- src/stlb_refill.sv
/*
 * result stage: pending requester, way choice with LFSR,
 * array writes and forward to the ITLB or DTLB
 */
`timescale 1ns/10ps

module stlb_refill #(
    parameter int STLB_WAYS = 2
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       flush_i,
    input  logic                       req_itlb_i,
    input  logic                       req_dtlb_i,
    input  logic                       lookup_valid_i,
    input  logic                       hit_i,
    input  stlb_pkg::stlb_pte_t         hit_pte_i,
    input  logic [stlb_pkg::VPN_W-1:0]   hit_vpn_i,
    input  logic [stlb_pkg::ASID_W-1:0]  hit_asid_i,
    input  logic                       ptw_update_valid_i,
    input  logic [stlb_pkg::VPN_W-1:0]   ptw_update_vpn_i,
    input  logic [stlb_pkg::ASID_W-1:0]  ptw_update_asid_i,
    input  stlb_pkg::stlb_pte_t         ptw_update_pte_i,
    input  logic [STLB_WAYS-1:0]         wr_set_valid_i,
    output logic [STLB_WAYS-1:0]         wr_en_way_o,
    output logic [stlb_pkg::VPN_W-1:0]   wr_vpn_o,
    output logic [stlb_pkg::ASID_W-1:0]  wr_asid_o,
    output stlb_pkg::stlb_pte_t         wr_pte_o,
    output logic                       itlb_update_valid_o,
    output logic [stlb_pkg::VPN_W-1:0]   itlb_update_vpn_o,
    output logic [stlb_pkg::ASID_W-1:0]  itlb_update_asid_o,
    output stlb_pkg::stlb_pte_t         itlb_update_pte_o,
    output logic                       dtlb_update_valid_o,
    output logic [stlb_pkg::VPN_W-1:0]   dtlb_update_vpn_o,
    output logic [stlb_pkg::ASID_W-1:0]  dtlb_update_asid_o,
    output stlb_pkg::stlb_pte_t         dtlb_update_pte_o
);

    import stlb_pkg::*;

    localparam int WAY_W = (STLB_WAYS > 1) ? $clog2(STLB_WAYS) : 1;

    logic              pend_itlb_q;
    logic              pend_dtlb_q;
    logic [LFSR_W-1:0] lfsr_q;
    logic              all_valid;
    logic [WAY_W-1:0]  inv_way;
    logic [WAY_W-1:0]  rnd_way;
    logic [WAY_W-1:0]  repl_way;
    logic              hit_itlb;
    logic              hit_dtlb;
    logic              fwd_itlb;
    logic              fwd_dtlb;

    ////////////////////
    // way choice
    ////////////////////

    assign all_valid = &wr_set_valid_i;

    // lowest invalid way wins
    always_comb begin
        inv_way = '0;
        for (int w = STLB_WAYS - 1; w >= 0; w--) begin
            if (!wr_set_valid_i[w]) begin
                inv_way = WAY_W'(w);
            end
        end
    end

    assign rnd_way  = WAY_W'(lfsr_q % STLB_WAYS);
    assign repl_way = all_valid ? rnd_way : inv_way;

    // x^8 + x^6 + x^5 + x^4 + 1
    // only steps when a full set is replaced
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lfsr_q <= LFSR_SEED;
        end else if (ptw_update_valid_i && all_valid) begin
            lfsr_q <= {lfsr_q[LFSR_W-2:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
        end
    end

    // array write, one-hot way
    always_comb begin
        wr_en_way_o = '0;
        if (ptw_update_valid_i) begin
            wr_en_way_o[repl_way] = 1'b1;
        end
    end

    assign wr_vpn_o  = ptw_update_vpn_i;
    assign wr_asid_o = ptw_update_asid_i;
    assign wr_pte_o  = ptw_update_pte_i;

    ////////////////////
    // pending requester
    ////////////////////

    // new lookup miss overwrites, walker update retires
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pend_itlb_q <= 1'b0;
            pend_dtlb_q <= 1'b0;
        end else if (flush_i) begin
            pend_itlb_q <= 1'b0;
            pend_dtlb_q <= 1'b0;
        end else if (lookup_valid_i && !hit_i) begin
            pend_itlb_q <= req_itlb_i;
            pend_dtlb_q <= req_dtlb_i;
        end else if (ptw_update_valid_i) begin
            pend_itlb_q <= 1'b0;
            pend_dtlb_q <= 1'b0;
        end
    end

    ////////////////////
    // forward to TLBs
    ////////////////////

    assign hit_itlb = lookup_valid_i & hit_i & req_itlb_i;
    assign hit_dtlb = lookup_valid_i & hit_i & req_dtlb_i;
    assign fwd_itlb = ptw_update_valid_i & pend_itlb_q;
    assign fwd_dtlb = ptw_update_valid_i & pend_dtlb_q;

    // walker fill takes the port over a same-cycle hit
    always_comb begin
        itlb_update_valid_o = fwd_itlb | hit_itlb;
        itlb_update_vpn_o   = fwd_itlb ? ptw_update_vpn_i : hit_vpn_i;
        itlb_update_asid_o  = fwd_itlb ? ptw_update_asid_i : hit_asid_i;
        itlb_update_pte_o   = PTE_ZERO;
        if (fwd_itlb) begin
            itlb_update_pte_o = ptw_update_pte_i;
        end else if (hit_itlb) begin
            itlb_update_pte_o = hit_pte_i;
        end
    end

    always_comb begin
        dtlb_update_valid_o = fwd_dtlb | hit_dtlb;
        dtlb_update_vpn_o   = fwd_dtlb ? ptw_update_vpn_i : hit_vpn_i;
        dtlb_update_asid_o  = fwd_dtlb ? ptw_update_asid_i : hit_asid_i;
        dtlb_update_pte_o   = PTE_ZERO;
        if (fwd_dtlb) begin
            dtlb_update_pte_o = ptw_update_pte_i;
        end else if (hit_dtlb) begin
            dtlb_update_pte_o = hit_pte_i;
        end
    end

endmodule

//--- src/stlb_lookup.sv
/*
 * execute stage: valid bits, tag and PTE arrays per way,
 * registered request and way compare with PTE select
 */
`timescale 1ns/10ps

module stlb_lookup #(
    parameter int STLB_SETS = 64,
    parameter int STLB_WAYS = 2
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       flush_i,
    input  logic                       rd_en_i,
    input  logic [stlb_pkg::VPN_W-1:0]   rd_vpn_i,
    input  logic [stlb_pkg::ASID_W-1:0]  rd_asid_i,
    input  logic [STLB_WAYS-1:0]         wr_en_way_i,
    input  logic [stlb_pkg::VPN_W-1:0]   wr_vpn_i,
    input  logic [stlb_pkg::ASID_W-1:0]  wr_asid_i,
    input  stlb_pkg::stlb_pte_t         wr_pte_i,
    input  logic [stlb_pkg::VPN_W-1:0]   wr_set_vpn_i,
    output logic                       lookup_valid_o,
    output logic                       hit_o,
    output stlb_pkg::stlb_pte_t         hit_pte_o,
    output logic [stlb_pkg::VPN_W-1:0]   hit_vpn_o,
    output logic [stlb_pkg::ASID_W-1:0]  hit_asid_o,
    output logic [STLB_WAYS-1:0]         wr_set_valid_o
);

    import stlb_pkg::*;

    localparam int IDX_W = $clog2(STLB_SETS);

    logic [STLB_SETS-1:0][STLB_WAYS-1:0] valid_q;
    logic [IDX_W-1:0]     rd_idx;
    logic [IDX_W-1:0]     wr_idx;
    stlb_tag_t            tag_wr;
    stlb_tag_t            tag_rd [STLB_WAYS];
    stlb_pte_t            pte_rd [STLB_WAYS];
    logic [STLB_WAYS-1:0] way_match;

    // cycle 1 copies of the request
    logic                 lookup_valid_q;
    logic [VPN_W-1:0]     req_vpn_q;
    logic [ASID_W-1:0]    req_asid_q;
    logic [STLB_WAYS-1:0] set_valid_q;

    // low vpn bits pick the set
    assign rd_idx = rd_vpn_i[IDX_W-1:0];
    assign wr_idx = wr_vpn_i[IDX_W-1:0];
    assign tag_wr = '{vpn: wr_vpn_i, asid: wr_asid_i};

    // valid ways of the set the walker fills
    assign wr_set_valid_o = valid_q[wr_set_vpn_i[IDX_W-1:0]];

    ////////////////////
    // valid bits
    ////////////////////

    // flush beats a same-cycle fill
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else begin
            for (int w = 0; w < STLB_WAYS; w++) begin
                if (wr_en_way_i[w]) begin
                    valid_q[wr_idx][w] <= 1'b1;
                end
            end
        end
    end

    // request regs, a flush kills the lookup in flight
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lookup_valid_q <= 1'b0;
            set_valid_q    <= '0;
            req_vpn_q      <= '0;
            req_asid_q     <= '0;
        end else begin
            lookup_valid_q <= rd_en_i;
            if (rd_en_i) begin
                set_valid_q <= flush_i ? '0 : valid_q[rd_idx];
                req_vpn_q   <= rd_vpn_i;
                req_asid_q  <= rd_asid_i;
            end
        end
    end

    ////////////////////
    // arrays per way
    ////////////////////

    for (genvar w = 0; w < STLB_WAYS; w++) begin : gen_way
        stlb_entry_ram #(
            .entry_t(stlb_tag_t),
            .DEPTH  (STLB_SETS)
        ) u_tag_ram (
            .clk_i    (clk_i),
            .rst_ni   (rst_ni),
            .rd_en_i  (rd_en_i),
            .rd_addr_i(rd_idx),
            .we_i     (wr_en_way_i[w]),
            .wr_addr_i(wr_idx),
            .wr_data_i(tag_wr),
            .rd_data_o(tag_rd[w])
        );

        stlb_entry_ram #(
            .entry_t(stlb_pte_t),
            .DEPTH  (STLB_SETS)
        ) u_pte_ram (
            .clk_i    (clk_i),
            .rst_ni   (rst_ni),
            .rd_en_i  (rd_en_i),
            .rd_addr_i(rd_idx),
            .we_i     (wr_en_way_i[w]),
            .wr_addr_i(wr_idx),
            .wr_data_i(wr_pte_i),
            .rd_data_o(pte_rd[w])
        );

        // full vpn, asid unless global
        assign way_match[w] = set_valid_q[w] && (tag_rd[w].vpn == req_vpn_q)
                           && ((tag_rd[w].asid == req_asid_q) || pte_rd[w].g);
    end

    // hitting way payload, cycle 1
    always_comb begin
        hit_pte_o = PTE_ZERO;
        for (int w = 0; w < STLB_WAYS; w++) begin
            if (way_match[w]) begin
                hit_pte_o = pte_rd[w];
            end
        end
    end

    assign lookup_valid_o = lookup_valid_q;
    assign hit_o          = lookup_valid_q & (|way_match);
    assign hit_vpn_o      = req_vpn_q;
    assign hit_asid_o     = req_asid_q;

endmodule

//--- src/stlb_miss_arbiter.sv
/*
 * decode stage that picks one ITLB or DTLB miss per cycle,
 * drives the array read and registers the requester
 */
`timescale 1ns/10ps

module stlb_miss_arbiter (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       itlb_en_i,
    input  logic                       dtlb_en_i,
    input  logic [stlb_pkg::ASID_W-1:0]  asid_i,
    input  logic                       itlb_access_i,
    input  logic                       itlb_hit_i,
    input  logic [stlb_pkg::VADDR_W-1:0] itlb_vaddr_i,
    input  logic                       dtlb_access_i,
    input  logic                       dtlb_hit_i,
    input  logic [stlb_pkg::VADDR_W-1:0] dtlb_vaddr_i,
    output logic                       itlb_miss_o,
    output logic                       dtlb_miss_o,
    output logic                       rd_en_o,
    output logic [stlb_pkg::VPN_W-1:0]   rd_vpn_o,
    output logic [stlb_pkg::ASID_W-1:0]  rd_asid_o,
    output logic                       stlb_access_o,
    output logic                       req_itlb_o,
    output logic                       req_dtlb_o
);

    import stlb_pkg::*;

    logic itlb_sel;
    logic dtlb_sel;
    logic access_q;
    logic req_itlb_q;
    logic req_dtlb_q;

    // instruction side only when data side is idle
    assign itlb_sel = itlb_en_i & itlb_access_i & ~itlb_hit_i & ~dtlb_access_i;
    assign dtlb_sel = dtlb_en_i & dtlb_access_i & ~dtlb_hit_i;

    assign itlb_miss_o = itlb_sel;
    assign dtlb_miss_o = dtlb_sel;

    // read request into the lookup in the same cycle
    assign rd_en_o   = itlb_sel | dtlb_sel;
    assign rd_vpn_o  = itlb_sel ? itlb_vaddr_i[VADDR_W-1:PAGE_OFFSET_W]
                                : dtlb_vaddr_i[VADDR_W-1:PAGE_OFFSET_W];
    assign rd_asid_o = asid_i;

    ////////////////////
    // requester regs
    ////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            access_q   <= 1'b0;
            req_itlb_q <= 1'b0;
            req_dtlb_q <= 1'b0;
        end else begin
            access_q   <= itlb_sel | dtlb_sel;
            req_itlb_q <= itlb_sel;
            req_dtlb_q <= dtlb_sel;
        end
    end

    assign stlb_access_o = access_q;
    assign req_itlb_o    = req_itlb_q;
    assign req_dtlb_o    = req_dtlb_q;

endmodule

//--- src/stlb_entry_ram.sv
/*
 * single-way entry array, registered read and separate write port
 */
`timescale 1ns/10ps

module stlb_entry_ram #(
    parameter type entry_t = logic,
    parameter int  DEPTH   = 64
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic                     rd_en_i,
    input  logic [$clog2(DEPTH)-1:0] rd_addr_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] wr_addr_i,
    input  entry_t                   wr_data_i,
    output entry_t                   rd_data_o
);

    // storage, one word per set
    entry_t mem_q [DEPTH];
    entry_t rd_data_q;

    // write port
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[wr_addr_i] <= wr_data_i;
        end
    end

    // read port, same-set write gives old word
    // holds last word while rd_en_i is low
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_data_q <= '0;
        end else if (rd_en_i) begin
            rd_data_q <= mem_q[rd_addr_i];
        end
    end

    assign rd_data_o = rd_data_q;

endmodule

//--- src/stlb_pkg.sv
/*
 * shared TLB package: Sv39 widths, tag and PTE types,
 * LFSR width and reset values
 */
package stlb_pkg;

    ////////////////////
    // address widths
    ////////////////////

    // Sv39 virtual page number, bits 38:12 of the vaddr
    localparam int VPN_W         = 27;
    localparam int VADDR_W       = 39;
    localparam int PAGE_OFFSET_W = 12;
    localparam int ASID_W        = 16;
    localparam int PPN_W         = 44;

    ////////////////////
    // entry types
    ////////////////////

    // translation payload returned to the small TLBs
    typedef struct packed {
        logic [PPN_W-1:0] ppn;
        // global mapping, ignores the asid on compare
        logic             g;
        logic             r;
        logic             w;
        logic             x;
        logic             u;
        logic             a;
        logic             d;
    } stlb_pte_t;

    // tag word, full vpn plus owning asid
    typedef struct packed {
        logic [VPN_W-1:0]  vpn;
        logic [ASID_W-1:0] asid;
    } stlb_tag_t;

    ////////////////////
    // replacement
    ////////////////////

    localparam int LFSR_W = 8;
    // any nonzero seed keeps the sequence alive
    localparam logic [LFSR_W-1:0] LFSR_SEED = 8'hA5;

    // idle value on the update ports
    localparam stlb_pte_t PTE_ZERO = '0;

endpackage
